// ==== src/blake2_pkg.sv ====
// BLAKE2b package with word types, IV and SIGMA tables, G index maps, request struct and FSM enums
`default_nettype none

package blake2_pkg;

  typedef logic [63:0] word_t;
  typedef logic [7:0][63:0] state_t;
  typedef logic [15:0][63:0] block_t;

  localparam int NUM_ROUNDS = 12;

  // Word i sits at bits 64*i+63 : 64*i
  localparam state_t IV = {
    64'h5BE0CD19137E2179,
    64'h1F83D9ABFB41BD6B,
    64'h9B05688C2B3E6C1F,
    64'h510E527FADE682D1,
    64'hA54FF53A5F1D36F1,
    64'h3C6EF372FE94F82B,
    64'hBB67AE8584CAA73B,
    64'h6A09E667F3BCC908
  };

  // Message word schedule, one row per round modulo 10
  localparam logic [3:0] SIGMA [10][16] = '{
    '{ 0,  1,  2,  3,  4,  5,  6,  7,  8,  9, 10, 11, 12, 13, 14, 15},
    '{14, 10,  4,  8,  9, 15, 13,  6,  1, 12,  0,  2, 11,  7,  5,  3},
    '{11,  8, 12,  0,  5,  2, 15, 13, 10, 14,  3,  6,  7,  1,  9,  4},
    '{ 7,  9,  3,  1, 13, 12, 11, 14,  2,  6,  5, 10,  4,  0, 15,  8},
    '{ 9,  0,  5,  7,  2,  4, 10, 15, 14,  1, 11, 12,  6,  8,  3, 13},
    '{ 2, 12,  6, 10,  0, 11,  8,  3,  4, 13,  7,  5, 15, 14,  1,  9},
    '{12,  5,  1, 15, 14, 13,  4, 10,  0,  7,  6,  3,  9,  2,  8, 11},
    '{13, 11,  7, 14, 12,  1,  3,  9,  5,  0, 15,  4,  8,  6, 10,  2},
    '{ 6, 15, 14,  9, 11,  3,  0,  8, 12,  2, 13,  7,  1,  4, 10,  5},
    '{10,  2,  8,  4,  7,  6,  1,  5, 15, 11,  9, 14,  3, 12, 13,  0}
  };

  // Work vector indices a, b, c, d for each of the four column G functions
  localparam logic [3:0] G_MAPPING [16] = '{
    0, 4,  8, 12,
    1, 5,  9, 13,
    2, 6, 10, 14,
    3, 7, 11, 15
  };

  // Same for the diagonal layer
  localparam logic [3:0] G_MAPPING_DIAG [16] = '{
    0, 5, 10, 15,
    1, 6, 11, 12,
    2, 7,  8, 13,
    3, 4,  9, 14
  };

  // Request from the controller to the compression core
  typedef struct packed {
    state_t      h;
    block_t      m;
    logic [63:0] t;
    logic        last;
  } compress_req_t;

  typedef enum logic [1:0] {
    CTRL_IDLE,
    CTRL_WAIT_ACK,
    CTRL_NEXT,
    CTRL_OUT
  } ctrl_state_e;

  typedef enum logic [1:0] {
    CORE_IDLE,
    CORE_ROUNDS,
    CORE_DONE
  } core_state_e;

endpackage

`default_nettype wire

// ==== src/blake2_g.sv ====
// BLAKE2b G mixing function, combinational, on four work words and two message words
`default_nettype none

module blake2_g (
  input  blake2_pkg::word_t i_a,
  input  blake2_pkg::word_t i_b,
  input  blake2_pkg::word_t i_c,
  input  blake2_pkg::word_t i_d,
  input  blake2_pkg::word_t i_m0,
  input  blake2_pkg::word_t i_m1,
  output blake2_pkg::word_t o_a,
  output blake2_pkg::word_t o_b,
  output blake2_pkg::word_t o_c,
  output blake2_pkg::word_t o_d
);
  import blake2_pkg::*;

  word_t a1, b1, c1, d1;
  word_t d1_x, b1_x, d2_x, b2_x;

  // First half uses m0 with rotations 32 and 24
  assign a1   = i_a + i_b + i_m0;
  assign d1_x = i_d ^ a1;
  assign d1   = {d1_x[31:0], d1_x[63:32]};
  assign c1   = i_c + d1;
  assign b1_x = i_b ^ c1;
  assign b1   = {b1_x[23:0], b1_x[63:24]};

  // Second half uses m1 with rotations 16 and 63
  assign o_a  = a1 + b1 + i_m1;
  assign d2_x = d1 ^ o_a;
  assign o_d  = {d2_x[15:0], d2_x[63:16]};
  assign o_c  = c1 + o_d;
  assign b2_x = b1 ^ o_c;
  // Rotating right by 63 is a rotate left by one
  assign o_b  = {b2_x[62:0], b2_x[63]};

endmodule

`default_nettype wire

// ==== src/blake2_compress.sv ====
// BLAKE2b compression core with column and diagonal G layers behind a four-phase req/ack link
`default_nettype none

module blake2_compress #(
  parameter int NUM_ROUNDS = blake2_pkg::NUM_ROUNDS
) (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  logic                      i_req,
  input  blake2_pkg::compress_req_t i_creq,
  output logic                      o_ack,
  output blake2_pkg::state_t        o_h_out
);
  import blake2_pkg::*;

  localparam int HALF_W = $clog2(2 * NUM_ROUNDS);
  localparam logic [HALF_W-1:0] LAST_HALF = HALF_W'(2 * NUM_ROUNDS - 1);

  core_state_e       state;
  logic [HALF_W-1:0] half_cnt;
  logic [3:0]        sigma_row;
  block_t            m_r;
  logic [15:0][63:0] v;
  logic [15:0][63:0] v_col;
  logic [15:0][63:0] v_diag;
  word_t             col_out [16];
  word_t             diag_out [16];

  // Two half-round steps per round, so the round is the upper counter bits
  assign sigma_row = 4'(32'(half_cnt >> 1) % 10);

  for (genvar gi = 0; gi < 4; gi++) begin : g_layer
    blake2_g u_g_col (
      .i_a  (v[G_MAPPING[4*gi+0]]),
      .i_b  (v[G_MAPPING[4*gi+1]]),
      .i_c  (v[G_MAPPING[4*gi+2]]),
      .i_d  (v[G_MAPPING[4*gi+3]]),
      .i_m0 (m_r[SIGMA[sigma_row][2*gi]]),
      .i_m1 (m_r[SIGMA[sigma_row][2*gi+1]]),
      .o_a  (col_out[4*gi+0]),
      .o_b  (col_out[4*gi+1]),
      .o_c  (col_out[4*gi+2]),
      .o_d  (col_out[4*gi+3])
    );

    blake2_g u_g_diag (
      .i_a  (v[G_MAPPING_DIAG[4*gi+0]]),
      .i_b  (v[G_MAPPING_DIAG[4*gi+1]]),
      .i_c  (v[G_MAPPING_DIAG[4*gi+2]]),
      .i_d  (v[G_MAPPING_DIAG[4*gi+3]]),
      .i_m0 (m_r[SIGMA[sigma_row][8+2*gi]]),
      .i_m1 (m_r[SIGMA[sigma_row][8+2*gi+1]]),
      .o_a  (diag_out[4*gi+0]),
      .o_b  (diag_out[4*gi+1]),
      .o_c  (diag_out[4*gi+2]),
      .o_d  (diag_out[4*gi+3])
    );
  end

  // Scatter the G outputs back to their work vector slots
  always_comb begin
    for (int k = 0; k < 16; k++) begin
      v_col[G_MAPPING[k]]       = col_out[k];
      v_diag[G_MAPPING_DIAG[k]] = diag_out[k];
    end
  end

  // Work vector and message block carry no reset
  always_ff @(posedge i_clk) begin
    if (state == CORE_IDLE && i_req) begin
      m_r <= i_creq.m;
      for (int i = 0; i < 8; i++) begin
        v[i] <= i_creq.h[i];
      end
      v[8]  <= IV[0];
      v[9]  <= IV[1];
      v[10] <= IV[2];
      v[11] <= IV[3];
      // Only the low half of the counter is used, the high half is zero
      v[12] <= IV[4] ^ i_creq.t;
      v[13] <= IV[5];
      v[14] <= IV[6] ^ {64{i_creq.last}};
      v[15] <= IV[7];
    end else if (state == CORE_ROUNDS) begin
      v <= half_cnt[0] ? v_diag : v_col;
    end
  end

  // The request h stays stable while req is high, so it is read directly here
  always_ff @(posedge i_clk) begin
    if (state == CORE_ROUNDS && half_cnt == LAST_HALF) begin
      for (int i = 0; i < 8; i++) begin
        o_h_out[i] <= i_creq.h[i] ^ v_diag[i] ^ v_diag[i+8];
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state    <= CORE_IDLE;
      half_cnt <= '0;
      o_ack    <= 1'b0;
    end else begin
      case (state)
        CORE_IDLE: begin
          half_cnt <= '0;
          if (i_req) begin
            state <= CORE_ROUNDS;
          end
        end
        CORE_ROUNDS: begin
          half_cnt <= half_cnt + 1'b1;
          if (half_cnt == LAST_HALF) begin
            o_ack <= 1'b1;
            state <= CORE_DONE;
          end
        end
        CORE_DONE: begin
          // Close the handshake once the controller has taken the result
          if (!i_req) begin
            o_ack <= 1'b0;
            state <= CORE_IDLE;
          end
        end
        default: state <= CORE_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/blake2_ctrl.sv ====
// BLAKE2b message controller with chaining value, byte counter, handshakes and error detection
`default_nettype none

module blake2_ctrl (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  blake2_pkg::block_t        i_block,
  input  logic                      i_new_block,
  input  logic                      i_final_block,
  input  logic [7:0]                i_last_bytes,
  input  logic [7:0]                i_digest_len,
  input  logic [7:0]                i_key_len,
  input  logic                      i_val,
  output logic                      o_rdy,
  output blake2_pkg::state_t        o_digest,
  output logic                      o_val,
  output logic                      o_err,
  input  logic                      i_rdy,
  output logic                      o_req,
  output blake2_pkg::compress_req_t o_creq,
  input  logic                      i_ack,
  input  blake2_pkg::state_t        i_h_out
);
  import blake2_pkg::*;

  ctrl_state_e state;
  state_t      h;
  state_t      h_init;
  block_t      m_r;
  logic [63:0] t;
  logic [63:0] t_next;
  logic [63:0] byte_inc;
  logic [63:0] param_word;
  logic        last_r;
  logic        take;
  logic        start_err;

  assign take = i_val && o_rdy;

  // Parameter word 0: digest length, key length, fanout 1, depth 1, leaf length 0
  assign param_word = {32'd0, 8'd1, 8'd1, i_key_len, i_digest_len};

  always_comb begin
    h_init    = IV;
    h_init[0] = IV[0] ^ param_word;
  end

  assign start_err = !i_new_block || (i_digest_len == 8'd0) || (i_digest_len > 8'd64);

  // A start block restarts the count, the final block adds only its valid bytes
  assign byte_inc = i_final_block ? 64'(i_last_bytes) : 64'd128;
  assign t_next   = (state == CTRL_IDLE) ? byte_inc : t + byte_inc;

  assign o_creq.h    = h;
  assign o_creq.m    = m_r;
  assign o_creq.t    = t;
  assign o_creq.last = last_r;

  // The chaining value doubles as the digest once the final block is done
  assign o_digest = h;

  always_ff @(posedge i_clk) begin
    if (take && (state == CTRL_NEXT || (state == CTRL_IDLE && !start_err))) begin
      m_r    <= i_block;
      t      <= t_next;
      last_r <= i_final_block;
      if (state == CTRL_IDLE) begin
        h <= h_init;
      end
    end else if (state == CTRL_WAIT_ACK && o_req && i_ack) begin
      h <= i_h_out;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= CTRL_IDLE;
      o_rdy <= 1'b0;
      o_val <= 1'b0;
      o_err <= 1'b0;
      o_req <= 1'b0;
    end else begin
      o_err <= 1'b0;
      case (state)
        CTRL_IDLE: begin
          o_rdy <= 1'b1;
          if (take) begin
            if (start_err) begin
              // Bad start is consumed and dropped
              o_err <= 1'b1;
            end else begin
              o_rdy <= 1'b0;
              o_req <= 1'b1;
              state <= CTRL_WAIT_ACK;
            end
          end
        end
        CTRL_WAIT_ACK: begin
          if (o_req && i_ack) begin
            o_req <= 1'b0;
          end else if (!o_req && !i_ack) begin
            // Four-phase cycle complete
            if (last_r) begin
              o_val <= 1'b1;
              state <= CTRL_OUT;
            end else begin
              o_rdy <= 1'b1;
              state <= CTRL_NEXT;
            end
          end
        end
        CTRL_NEXT: begin
          if (take) begin
            o_rdy <= 1'b0;
            o_req <= 1'b1;
            state <= CTRL_WAIT_ACK;
          end
        end
        CTRL_OUT: begin
          if (i_rdy) begin
            o_val <= 1'b0;
            o_rdy <= 1'b1;
            state <= CTRL_IDLE;
          end
        end
        default: state <= CTRL_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/blake2_top.sv ====
// BLAKE2b top level joining the message controller and the compression core
`default_nettype none

module blake2_top #(
  parameter int NUM_ROUNDS = blake2_pkg::NUM_ROUNDS
) (
  input  logic               i_clk,
  input  logic               i_rst,
  input  blake2_pkg::block_t i_block,
  input  logic               i_new_block,
  input  logic               i_final_block,
  input  logic [7:0]         i_last_bytes,
  input  logic [7:0]         i_digest_len,
  input  logic [7:0]         i_key_len,
  input  logic               i_val,
  output logic               o_rdy,
  output blake2_pkg::state_t o_digest,
  output logic               o_val,
  output logic               o_err,
  input  logic               i_rdy
);
  import blake2_pkg::*;

  // Four-phase link between controller and core
  logic          req;
  logic          ack;
  compress_req_t creq;
  state_t        h_out;

  blake2_ctrl u_ctrl (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_block       (i_block),
    .i_new_block   (i_new_block),
    .i_final_block (i_final_block),
    .i_last_bytes  (i_last_bytes),
    .i_digest_len  (i_digest_len),
    .i_key_len     (i_key_len),
    .i_val         (i_val),
    .o_rdy         (o_rdy),
    .o_digest      (o_digest),
    .o_val         (o_val),
    .o_err         (o_err),
    .i_rdy         (i_rdy),
    .o_req         (req),
    .o_creq        (creq),
    .i_ack         (ack),
    .i_h_out       (h_out)
  );

  blake2_compress #(
    .NUM_ROUNDS (NUM_ROUNDS)
  ) u_compress (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_req   (req),
    .i_creq  (creq),
    .o_ack   (ack),
    .o_h_out (h_out)
  );

endmodule

`default_nettype wire

// ==== dv/blake2_checker.sv ====
// Bound assertions on the BLAKE2b top level for output hold, ready/valid, req/ack order and error pulse
`default_nettype none

module blake2_checker (
  input logic               i_clk,
  input logic               i_rst,
  input logic               i_in_rdy,
  input logic               i_out_val,
  input logic               i_out_rdy,
  input blake2_pkg::state_t i_digest,
  input logic               i_err,
  input logic               i_req,
  input logic               i_ack
);
  timeunit 1ns;
  timeprecision 1ps;

  a_val_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    i_out_val && !i_out_rdy |=> i_out_val && $stable(i_digest))
    else $error("o_val dropped or o_digest changed without i_rdy");

  a_rdy_val: assert property (@(posedge i_clk) disable iff (i_rst) !(i_in_rdy && i_out_val))
    else $error("o_rdy and o_val high together");

  // Four-phase order on the internal link
  a_req_hold: assert property (@(posedge i_clk) disable iff (i_rst) i_req && !i_ack |=> i_req)
    else $error("req dropped before ack");
  a_ack_hold: assert property (@(posedge i_clk) disable iff (i_rst) i_req && i_ack |=> i_ack)
    else $error("ack dropped before req");
  a_no_rerequest: assert property (@(posedge i_clk) disable iff (i_rst)
    i_ack && !i_req |=> !i_req)
    else $error("req raised while ack still high");
  a_ack_after_req: assert property (@(posedge i_clk) disable iff (i_rst) $rose(i_ack) |-> i_req)
    else $error("ack raised without req");

  a_err_pulse: assert property (@(posedge i_clk) disable iff (i_rst) i_err |=> !i_err)
    else $error("o_err longer than one cycle");

endmodule

bind blake2_top blake2_checker u_checker (
  .i_clk     (i_clk),
  .i_rst     (i_rst),
  .i_in_rdy  (o_rdy),
  .i_out_val (o_val),
  .i_out_rdy (i_rdy),
  .i_digest  (o_digest),
  .i_err     (o_err),
  .i_req     (req),
  .i_ack     (ack)
);

`default_nettype wire

// ==== dv/blake2_ref.svh ====
// Reference BLAKE2b model (mix, compression, message padding) and a 16-bit Fibonacci LFSR step
`ifndef BLAKE2_REF_SVH
`define BLAKE2_REF_SVH

localparam logic [15:0] LFSR_SEED = 16'd51045;

// Taps for x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  logic fb;
  fb = s[15] ^ s[13] ^ s[12] ^ s[10];
  return {s[14:0], fb};
endfunction

function automatic logic [63:0] rotr64(input logic [63:0] x, input int n);
  return (x >> n) | (x << (64 - n));
endfunction

function automatic logic [15:0][63:0] ref_mix(input logic [15:0][63:0] v, input int a,
                                              input int b, input int c, input int d,
                                              input logic [63:0] x, input logic [63:0] y);
  v[a] = v[a] + v[b] + x;
  v[d] = rotr64(v[d] ^ v[a], 32);
  v[c] = v[c] + v[d];
  v[b] = rotr64(v[b] ^ v[c], 24);
  v[a] = v[a] + v[b] + y;
  v[d] = rotr64(v[d] ^ v[a], 16);
  v[c] = v[c] + v[d];
  v[b] = rotr64(v[b] ^ v[c], 63);
  return v;
endfunction

function automatic state_t ref_compress(input state_t h, input block_t m,
                                        input logic [63:0] t, input bit last);
  logic [15:0][63:0] v;
  state_t            r;
  int                s;
  for (int i = 0; i < 8; i++) begin
    v[i]     = h[i];
    v[i + 8] = IV[i];
  end
  v[12] = v[12] ^ t;
  if (last) begin
    v[14] = ~v[14];
  end
  for (int rnd = 0; rnd < 12; rnd++) begin
    s = rnd % 10;
    for (int i = 0; i < 4; i++) begin
      v = ref_mix(v, i, 4 + i, 8 + i, 12 + i, m[SIGMA[s][2*i]], m[SIGMA[s][2*i+1]]);
    end
    // Diagonals start at a = i and step one column for each of b, c and d
    for (int i = 0; i < 4; i++) begin
      v = ref_mix(v, i, 4 + (i + 1) % 4, 8 + (i + 2) % 4, 12 + (i + 3) % 4,
                  m[SIGMA[s][8+2*i]], m[SIGMA[s][8+2*i+1]]);
    end
  end
  for (int i = 0; i < 8; i++) begin
    r[i] = h[i] ^ v[i] ^ v[i + 8];
  end
  return r;
endfunction

// Full hash of a message, a padded key block goes first when the key is not empty
function automatic state_t blake2b_ref(input byte unsigned msg[], input int nn,
                                       input byte unsigned key[]);
  state_t       h;
  block_t       blk;
  byte unsigned data[$];
  int           kk;
  int           total;
  int           nblk;
  logic [63:0]  t;
  kk = key.size();
  h = IV;
  h[0] = h[0] ^ 64'h0101_0000 ^ (64'(kk) << 8) ^ 64'(nn);
  foreach (key[k]) data.push_back(key[k]);
  while (kk > 0 && data.size() < 128) data.push_back(8'h00);
  foreach (msg[k]) data.push_back(msg[k]);
  total = data.size();
  nblk = (total + 127) / 128;
  t = 64'd0;
  for (int b = 0; b < nblk; b++) begin
    blk = '0;
    for (int j = 0; j < 128; j++) begin
      if (128 * b + j < total) blk[j/8][8*(j%8) +: 8] = data[128*b+j];
    end
    t = (b == nblk - 1) ? 64'(total) : t + 64'd128;
    h = ref_compress(h, blk, t, b == nblk - 1);
  end
  return h;
endfunction

`endif

// ==== dv/blake2_tb.sv ====
// Testbench for the BLAKE2b top level with stimulus, output sink, digest comparison and timeout
`default_nettype none

module blake2_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import blake2_pkg::*;

  `include "blake2_ref.svh"

  localparam int MAX_CYCLES = 5000;

  logic        i_clk;
  logic        i_rst;
  block_t      i_block;
  logic        i_new_block;
  logic        i_final_block;
  logic [7:0]  i_last_bytes;
  logic [7:0]  i_digest_len;
  logic [7:0]  i_key_len;
  logic        i_val;
  logic        o_rdy;
  state_t      o_digest;
  logic        o_val;
  logic        o_err;
  logic        i_rdy;

  logic [15:0] lfsr;
  state_t      exp_q[$];
  int          len_q[$];
  int          outstanding;
  int          err_pending;
  bit          bp_on;
  int          cycles;

  blake2_top #(.NUM_ROUNDS(12)) i_blake2_top (.*);

  always #50 i_clk = ~i_clk;

  task automatic stop_with_failure();
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    stop_with_failure();
  endtask

  // Only the first nn bytes carry the digest
  task automatic compare_digest(input string name, input state_t exp, input state_t act,
                                input int nn);
    for (int k = 0; k < nn; k++) begin
      if (exp[k/8][8*(k%8) +: 8] !== act[k/8][8*(k%8) +: 8]) begin
        $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
        stop_with_failure();
      end
    end
  endtask

  task automatic compare_err(input string name, input bit exp, input bit act);
    if (exp !== act) begin
      $display("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act);
      stop_with_failure();
    end
  endtask

  function automatic int rand_bits(input int n);
    int r;
    r = 0;
    for (int i = 0; i < n; i++) begin
      r = (r << 1) | int'(lfsr[15]);
      lfsr = lfsr_next(lfsr);
    end
    return r;
  endfunction

  task automatic make_bytes(input int n, output byte unsigned a[]);
    a = new[n];
    foreach (a[k]) a[k] = 8'(rand_bits(8));
  endtask

  // Called 10 ns after a rising edge, returns at the same point after the block is taken
  task automatic drive_block(input block_t blk, input bit nb, input bit fb,
                             input logic [7:0] lb, input logic [7:0] dl, input logic [7:0] kl);
    bit taken;
    i_block       = blk;
    i_new_block   = nb;
    i_final_block = fb;
    i_last_bytes  = lb;
    i_digest_len  = dl;
    i_key_len     = kl;
    i_val         = 1'b1;
    do begin
      taken = o_rdy;
      @(posedge i_clk);
      #10;
    end while (!taken);
    i_val = 1'b0;
  endtask

  task automatic send_message(input byte unsigned msg[], input int nn, input byte unsigned key[]);
    byte unsigned data[$];
    block_t       blk;
    int           kk;
    int           total;
    int           nblk;
    int           base;
    kk = key.size();
    exp_q.push_back(blake2b_ref(msg, nn, key));
    len_q.push_back(nn);
    outstanding++;
    foreach (key[k]) data.push_back(key[k]);
    while (kk > 0 && data.size() < 128) data.push_back(8'h00);
    foreach (msg[k]) data.push_back(msg[k]);
    total = data.size();
    nblk = (total + 127) / 128;
    for (int b = 0; b < nblk; b++) begin
      base = 128 * b;
      blk = '0;
      for (int j = 0; j < 128; j++) begin
        if (base + j < total) blk[j/8][8*(j%8) +: 8] = data[base+j];
      end
      drive_block(blk, b == 0, b == nblk - 1, (b == nblk - 1) ? 8'(total - base) : 8'd0,
                  8'(nn), 8'(kk));
    end
  endtask

  task automatic wait_idle_aligned();
    wait (outstanding == 0);
    @(posedge i_clk);
    #10;
  endtask

  initial begin : timeout
    cycles = 0;
    forever begin
      @(posedge i_clk);
      cycles++;
      if (cycles >= MAX_CYCLES) abort_run("Timeout: the DUT stopped making progress");
    end
  end

  // Values are stable at the falling edge, a digest there with i_rdy high leaves on the next edge
  initial begin : compare_proc
    state_t exp;
    int     nn;
    forever begin
      @(negedge i_clk);
      if (!i_rst && o_err) begin
        compare_err("o_err", err_pending > 0, 1'b1);
        err_pending--;
      end
      if (!i_rst && o_val && i_rdy) begin
        if (outstanding == 0) begin
          abort_run("A digest came out with no message outstanding");
        end else begin
          exp = exp_q.pop_front();
          nn = len_q.pop_front();
          compare_digest("o_digest", exp, o_digest, nn);
          outstanding--;
        end
      end
    end
  end

  // Output sink holding i_rdy low for a random number of cycles when back-pressure is on
  initial begin : sink
    int     hold;
    state_t held;
    hold = -1;
    forever begin
      @(posedge i_clk);
      #10;
      if (!o_val) begin
        i_rdy = 1'b0;
        hold = -1;
      end else begin
        if (hold < 0) begin
          hold = bp_on ? rand_bits(4) : 0;
          held = o_digest;
        end else begin
          compare_digest("o_digest held", held, o_digest, 64);
          compare_err("o_rdy during hold", 1'b0, o_rdy);
          if (hold > 0) hold--;
        end
        i_rdy = (hold == 0);
      end
    end
  end

  initial begin : stimulus
    byte unsigned msg[];
    byte unsigned key[];
    byte unsigned no_key[];
    block_t       blk;
    state_t       known;
    logic [511:0] abc_512;
    i_clk = 1'b0;
    i_rst = 1'b1;
    i_block = '0;
    i_new_block = 1'b0;
    i_final_block = 1'b0;
    i_last_bytes = 8'd0;
    i_digest_len = 8'd0;
    i_key_len = 8'd0;
    i_val = 1'b0;
    i_rdy = 1'b0;
    lfsr = LFSR_SEED;
    outstanding = 0;
    err_pending = 0;
    bp_on = 1'b0;
    repeat (16) @(posedge i_clk);
    #10;
    i_rst = 1'b0;
    compare_err("o_val after reset", 1'b0, o_val);
    compare_err("o_err after reset", 1'b0, o_err);
    @(posedge i_clk);
    #10;
    compare_err("o_rdy after reset", 1'b1, o_rdy);

    // Known answer from RFC 7693 Appendix A, first byte in the top bits
    abc_512 = {256'hBA80A53F981C4D0D6A2797B69F12F6E94C212F14685AC4B74B12BB6FDBFFA2D1,
               256'h7D87C5392AAB792DC252D5DE4533CC9518D38AA8DBF1925AB92386EDD4009923};
    for (int k = 0; k < 64; k++) known[k/8][8*(k%8) +: 8] = abc_512[511 - 8*k -: 8];
    msg = new[3];
    msg[0] = 8'h61;
    msg[1] = 8'h62;
    msg[2] = 8'h63;
    compare_digest("reference abc", known, blake2b_ref(msg, 64, no_key), 64);
    send_message(msg, 64, no_key);

    repeat (12) begin
      make_bytes(rand_bits(9) % 384 + 1, msg);
      send_message(msg, rand_bits(6) + 1, no_key);
    end

    repeat (8) begin
      make_bytes(rand_bits(6) + 1, key);
      make_bytes(rand_bits(7) + 1, msg);
      send_message(msg, rand_bits(6) + 1, key);
    end

    bp_on = 1'b1;
    repeat (6) begin
      make_bytes(rand_bits(8) + 1, msg);
      send_message(msg, rand_bits(6) + 1, no_key);
    end
    wait_idle_aligned();
    bp_on = 1'b0;

    // Start block without i_new_block, then one with digest length zero
    blk = '0;
    err_pending++;
    drive_block(blk, 1'b0, 1'b1, 8'd3, 8'd64, 8'd0);
    wait (err_pending == 0);
    make_bytes(rand_bits(8) + 1, msg);
    @(posedge i_clk);
    #10;
    send_message(msg, 32, no_key);
    wait_idle_aligned();
    err_pending++;
    drive_block(blk, 1'b1, 1'b1, 8'd3, 8'd0, 8'd0);
    wait (err_pending == 0);
    make_bytes(rand_bits(8) + 1, msg);
    @(posedge i_clk);
    #10;
    send_message(msg, 64, no_key);

    // Back-to-back messages with no idle gap on the input
    repeat (6) begin
      make_bytes(rand_bits(8) + 1, msg);
      send_message(msg, rand_bits(6) + 1, no_key);
    end

    wait_idle_aligned();
    repeat (4) @(posedge i_clk);
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+dv
src/blake2_pkg.sv
src/blake2_g.sv
src/blake2_compress.sv
src/blake2_ctrl.sv
src/blake2_top.sv
dv/blake2_checker.sv
dv/blake2_tb.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sim.f --top-module blake2_tb -o blake2_sim

run: compile
	./obj_dir/blake2_sim | tee /dev/stderr | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
